// ==== include/bus_params.svh ====
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

////////////////////////////////////////////////////////////
// Fares and revenue
////////////////////////////////////////////////////////////

`define BUS_FARE_STOP1   7'd30   // Per passenger boarding at stop 1
`define BUS_FARE_STOP2   7'd20   // Per passenger boarding at stop 2
`define BUS_REVENUE_MAX  7'd90   // Revenue saturates here
`define BUS_REFILL_COST  7'd10   // Paid out of revenue per refuel

////////////////////////////////////////////////////////////
// Gas
////////////////////////////////////////////////////////////

`define BUS_GAS_MAX      5'd20   // Full tank
`define BUS_GAS_REFILL   5'd10   // Added per refuel
`define BUS_GAS_PER_PAX  5'd5    // Burned per passenger at each burn point

////////////////////////////////////////////////////////////
// Stops and route
////////////////////////////////////////////////////////////

`define BUS_MAX_WAITING  2'd2    // Waiting group size limit
`define BUS_ROUTE_LEN    7       // Positions 0 to 6
`define BUS_MID_POS      3       // Refuel point between terminals

`endif

// ==== verilog/bus_route_pkg.sv ====
`include "bus_params.svh"

package bus_route_pkg;

    ////////////////////////////////////////////////////////////
    // Counts and levels
    ////////////////////////////////////////////////////////////

    typedef logic [1:0] pax_count_t;   // 0 to 2 passengers
    typedef logic [4:0] gas_t;         // 0 to 20
    typedef logic [6:0] revenue_t;     // 0 to 90

    // One-hot, bit 0 is stop 1 and the top bit is stop 2
    typedef logic [`BUS_ROUTE_LEN-1:0] route_pos_t;

    ////////////////////////////////////////////////////////////
    // Terminal sub-steps, listed in priority order
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        BURN,      // Arrival burn
        UNLOAD,    // One passenger leaves
        BOARD,     // Waiting group gets on
        PAY,       // Fare for the group
        REFUEL,    // Revenue into gas
        DEPART     // Move on, or wait
    } stop_phase_t;

endpackage

// ==== verilog/bus_display_pkg.sv ====
package bus_display_pkg;

    ////////////////////////////////////////////////////////////
    // Seven-segment display
    ////////////////////////////////////////////////////////////

    typedef logic [3:0] bcd_digit_t;   // One decimal digit
    typedef logic [6:0] segment_t;     // Active low, gfedcba
    typedef logic [3:0] digit_sel_t;   // Active-low anodes

    ////////////////////////////////////////////////////////////
    // LED bars
    ////////////////////////////////////////////////////////////

    // Thermometer style, 1 shows 10 and 2 shows 11
    typedef logic [1:0] pax_bar_t;

endpackage

// ==== verilog/bus_step_timer.sv ====
`timescale 1ns/1ps

module bus_step_timer #(
    parameter int STEP_CYCLES = 25_000_000
) (
    input  logic clk,
    input  logic global_clk,
    output logic step
);

    localparam int CNT_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge global_clk) begin
        if (global_clk) begin
            cnt  <= '0;
            step <= 1'b0;
        end else if (cnt == CNT_W'(STEP_CYCLES - 1)) begin
            cnt  <= '0;
            step <= 1'b1;    // One pulse per wrap
        end else begin
            cnt  <= cnt + 1'b1;
            step <= 1'b0;
        end
    end

    // The route controller expects isolated step pulses
    a_step_single : assert property (@(posedge clk) disable iff (global_clk)
        (STEP_CYCLES > 1) && step |=> !step)
        else $error("step held high for two cycles");

endmodule

// ==== verilog/stop_queue.sv ====
`timescale 1ns/1ps
`include "bus_params.svh"

module stop_queue (
    input  logic                    clk,
    input  logic                    global_clk,
    input  logic                    call,
    input  logic                    board,
    output bus_route_pkg::pax_count_t waiting
);

    import bus_route_pkg::*;

    pax_count_t next_waiting;

    always_comb begin
        next_waiting = waiting;
        if (board) begin
            // A call on the boarding edge starts a new group
            next_waiting = call ? pax_count_t'(1) : pax_count_t'(0);
        end else if (call && waiting < `BUS_MAX_WAITING) begin
            next_waiting = waiting + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge global_clk) begin
        if (global_clk) begin
            waiting <= '0;
        end else begin
            waiting <= next_waiting;
        end
    end

    a_waiting_max : assert property (@(posedge clk) disable iff (global_clk)
        waiting <= `BUS_MAX_WAITING)
        else $error("waiting above limit: %0d", waiting);

endmodule

// ==== verilog/bus_route_fsm.sv ====
`timescale 1ns/1ps
`include "bus_params.svh"

module bus_route_fsm (
    input  logic                       clk,
    input  logic                       global_clk,
    input  logic                       step,
    input  bus_route_pkg::pax_count_t  waiting_stop1,
    input  bus_route_pkg::pax_count_t  waiting_stop2,
    output logic                       board_stop1,
    output logic                       board_stop2,
    output bus_route_pkg::pax_count_t  on_board,
    output bus_route_pkg::gas_t        gas,
    output bus_route_pkg::revenue_t    revenue,
    output bus_route_pkg::route_pos_t  location
);

    import bus_route_pkg::*;

    logic        dir_up;        // Heading toward stop 2
    logic        burn_armed;    // Set on arrival at a terminal or the midpoint
    logic        unload_done;
    logic        board_done;
    logic        pay_done;

    stop_phase_t act;
    logic        at_stop1;
    logic        at_stop2;
    logic        at_term;
    logic        at_mid;
    pax_count_t  waiting_here;
    pax_count_t  waiting_far;
    revenue_t    fare;
    revenue_t    fare_total;
    logic [7:0]  pay_sum;
    revenue_t    revenue_paid;
    gas_t        burn_amt;
    gas_t        gas_burned;
    logic [5:0]  refill_sum;
    gas_t        gas_refilled;
    logic        can_refuel;
    logic        depart_ok;
    logic        move_up;
    route_pos_t  next_loc;
    logic        arrive_term;
    logic        arrive_mid;

    ////////////////////////////////////////////////////////////
    // Where the bus is and what the stop looks like
    ////////////////////////////////////////////////////////////

    assign at_stop1     = location[0];
    assign at_stop2     = location[`BUS_ROUTE_LEN-1];
    assign at_term      = at_stop1 | at_stop2;
    assign at_mid       = location[`BUS_MID_POS];

    assign waiting_here = at_stop1 ? waiting_stop1 : waiting_stop2;
    assign waiting_far  = at_stop1 ? waiting_stop2 : waiting_stop1;

    ////////////////////////////////////////////////////////////
    // Fare, burn and refuel arithmetic
    ////////////////////////////////////////////////////////////

    assign fare         = at_stop1 ? `BUS_FARE_STOP1 : `BUS_FARE_STOP2;
    assign fare_total   = revenue_t'(on_board) * fare;          // At most 60
    assign pay_sum      = {1'b0, revenue} + {1'b0, fare_total};
    assign revenue_paid = (pay_sum > {1'b0, `BUS_REVENUE_MAX}) ? `BUS_REVENUE_MAX
                                                               : pay_sum[6:0];

    assign burn_amt     = gas_t'(on_board) * `BUS_GAS_PER_PAX;
    assign gas_burned   = (gas > burn_amt) ? gas - burn_amt : '0;   // Saturates at empty

    assign refill_sum   = {1'b0, gas} + {1'b0, `BUS_GAS_REFILL};
    assign gas_refilled = (refill_sum > {1'b0, `BUS_GAS_MAX}) ? `BUS_GAS_MAX
                                                              : refill_sum[4:0];

    assign can_refuel   = (gas < `BUS_GAS_MAX) && (revenue >= `BUS_REFILL_COST);

    ////////////////////////////////////////////////////////////
    // Action select, first applicable one wins
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (burn_armed && on_board != '0) begin
            act = BURN;
        end else if (!at_term) begin
            // Travel positions only refuel at the midpoint
            act = (at_mid && on_board != '0 && can_refuel) ? REFUEL : DEPART;
        end else if (on_board != '0 && !unload_done) begin
            act = UNLOAD;
        end else if (waiting_here != '0 && !board_done) begin
            act = BOARD;
        end else if (board_done && !pay_done) begin
            act = PAY;
        end else if (can_refuel) begin
            act = REFUEL;
        end else begin
            act = DEPART;
        end
    end

    // Terminals hold the bus until there is a reason to go
    assign depart_ok   = !at_term || on_board != '0 || waiting_far != '0;

    assign move_up     = at_term ? at_stop1 : dir_up;
    assign next_loc    = move_up ? location << 1 : location >> 1;
    assign arrive_term = next_loc[0] | next_loc[`BUS_ROUTE_LEN-1];
    assign arrive_mid  = next_loc[`BUS_MID_POS];

    // Queue clears on the same edge that loads on_board
    assign board_stop1 = step && act == BOARD && at_stop1;
    assign board_stop2 = step && act == BOARD && at_stop2;

    ////////////////////////////////////////////////////////////
    // State update, one action per step
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge global_clk) begin
        if (global_clk) begin
            location    <= route_pos_t'(1);
            dir_up      <= 1'b1;
            on_board    <= '0;
            gas         <= '0;
            revenue     <= '0;
            burn_armed  <= 1'b0;
            unload_done <= 1'b0;
            board_done  <= 1'b0;
            pay_done    <= 1'b0;
        end else if (step) begin
            burn_armed <= 1'b0;          // Only lasts one step
            case (act)
                BURN: begin
                    gas <= gas_burned;
                end
                UNLOAD: begin
                    on_board <= on_board - 1'b1;
                    if (on_board == pax_count_t'(1)) begin
                        unload_done <= 1'b1;
                    end
                end
                BOARD: begin
                    on_board    <= waiting_here;
                    unload_done <= 1'b1;     // Keeps the new group aboard
                    board_done  <= 1'b1;
                end
                PAY: begin
                    revenue  <= revenue_paid;
                    pay_done <= 1'b1;
                end
                REFUEL: begin
                    revenue <= revenue - `BUS_REFILL_COST;
                    gas     <= gas_refilled;
                end
                DEPART: begin
                    if (depart_ok) begin
                        location   <= next_loc;
                        dir_up     <= move_up;
                        burn_armed <= arrive_term | arrive_mid;
                        if (arrive_term) begin
                            unload_done <= 1'b0;
                            board_done  <= 1'b0;
                            pay_done    <= 1'b0;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_loc_onehot : assert property (@(posedge clk) disable iff (global_clk)
        $onehot(location))
        else $error("location not one-hot: %h", location);

    a_gas_max : assert property (@(posedge clk) disable iff (global_clk)
        gas <= `BUS_GAS_MAX)
        else $error("gas above full tank: %0d", gas);

    a_revenue_max : assert property (@(posedge clk) disable iff (global_clk)
        revenue <= `BUS_REVENUE_MAX)
        else $error("revenue above cap: %0d", revenue);

endmodule

// ==== verilog/bus_display.sv ====
`timescale 1ns/1ps

module bus_display #(
    parameter int SCAN_BITS = 16
) (
    input  logic                        clk,
    input  logic                        global_clk,
    input  logic [1:0]                  waiting_stop1,
    input  logic [1:0]                  waiting_stop2,
    input  logic [1:0]                  on_board,
    input  logic [4:0]                  gas,
    input  logic [6:0]                  revenue,
    input  logic [6:0]                  location,
    output bus_display_pkg::digit_sel_t digit,
    output bus_display_pkg::segment_t   segments,
    output logic [15:0]                 led
);

    import bus_display_pkg::*;

    logic [SCAN_BITS+1:0] scan_cnt;
    logic [1:0]           scan_sel;
    bcd_digit_t           rev_ones;
    bcd_digit_t           rev_tens;
    bcd_digit_t           gas_ones;
    bcd_digit_t           gas_tens;
    bcd_digit_t           value;

    function automatic pax_bar_t pax_bar(input logic [1:0] count);
        case (count)
            2'd1:    pax_bar = 2'b10;
            2'd2:    pax_bar = 2'b11;
            default: pax_bar = 2'b00;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Digit scan
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge global_clk) begin
        if (global_clk) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign scan_sel = scan_cnt[SCAN_BITS+1:SCAN_BITS];   // Top two bits pick the digit

    assign rev_ones = bcd_digit_t'(revenue % 7'd10);
    assign rev_tens = bcd_digit_t'(revenue / 7'd10);
    assign gas_ones = bcd_digit_t'(gas % 5'd10);
    assign gas_tens = bcd_digit_t'(gas / 5'd10);

    always_comb begin
        case (scan_sel)
            2'd0: begin
                value = rev_ones;
                digit = 4'b1110;
            end
            2'd1: begin
                value = rev_tens;
                digit = 4'b1101;
            end
            2'd2: begin
                value = gas_ones;
                digit = 4'b1011;
            end
            default: begin
                value = gas_tens;
                digit = 4'b0111;
            end
        endcase
    end

    always_comb begin
        case (value)
            4'd1:    segments = 7'b1111001;
            4'd2:    segments = 7'b0100100;
            4'd3:    segments = 7'b0110000;
            4'd4:    segments = 7'b0011001;
            4'd5:    segments = 7'b0010010;
            4'd6:    segments = 7'b0000010;
            4'd7:    segments = 7'b1111000;
            4'd8:    segments = 7'b0000000;
            4'd9:    segments = 7'b0010000;
            default: segments = 7'b1000000;   // 0 and anything out of range
        endcase
    end

    ////////////////////////////////////////////////////////////
    // LED word
    ////////////////////////////////////////////////////////////

    assign led = {pax_bar(waiting_stop1), 1'b0, pax_bar(waiting_stop2),
                  pax_bar(on_board), 2'b00, location};

endmodule

// ==== verilog/bus_top.sv ====
`timescale 1ns/1ps

module bus_top #(
    parameter int STEP_CYCLES = 25_000_000,
    parameter int SCAN_BITS   = 16
) (
    input  logic                        clk,
    input  logic                        global_clk,
    input  logic                        call_stop1,
    input  logic                        call_stop2,
    output bus_display_pkg::digit_sel_t digit,
    output bus_display_pkg::segment_t   segments,
    output logic [15:0]                 led
);

    import bus_route_pkg::*;

    logic       step;
    pax_count_t waiting_stop1;
    pax_count_t waiting_stop2;
    logic       board_stop1;
    logic       board_stop2;
    pax_count_t on_board;
    gas_t       gas;
    revenue_t   revenue;
    route_pos_t location;

    bus_step_timer #(
        .STEP_CYCLES (STEP_CYCLES)
    ) step_timer_i (
        .clk        (clk),
        .global_clk (global_clk),
        .step       (step)
    );

    // One queue per terminal
    stop_queue stop1_queue_i (
        .clk        (clk),
        .global_clk (global_clk),
        .call       (call_stop1),
        .board      (board_stop1),
        .waiting    (waiting_stop1)
    );

    stop_queue stop2_queue_i (
        .clk        (clk),
        .global_clk (global_clk),
        .call       (call_stop2),
        .board      (board_stop2),
        .waiting    (waiting_stop2)
    );

    bus_route_fsm route_fsm_i (
        .clk           (clk),
        .global_clk    (global_clk),
        .step          (step),
        .waiting_stop1 (waiting_stop1),
        .waiting_stop2 (waiting_stop2),
        .board_stop1   (board_stop1),
        .board_stop2   (board_stop2),
        .on_board      (on_board),
        .gas           (gas),
        .revenue       (revenue),
        .location      (location)
    );

    bus_display #(
        .SCAN_BITS (SCAN_BITS)
    ) display_i (
        .clk           (clk),
        .global_clk    (global_clk),
        .waiting_stop1 (waiting_stop1),
        .waiting_stop2 (waiting_stop2),
        .on_board      (on_board),
        .gas           (gas),
        .revenue       (revenue),
        .location      (location),
        .digit         (digit),
        .segments      (segments),
        .led           (led)
    );

endmodule

// ==== tests/bus_tb.sv ====
`timescale 1ns/1ps
`include "bus_params.svh"

module bus_tb;

    localparam int STEP_CYCLES  = 4;
    localparam int SCAN_BITS    = 2;
    localparam int TRIP_TIMEOUT = 100 * STEP_CYCLES;   // Cycles allowed for one leg

    logic        clk;
    logic        global_clk;
    logic        call_stop1;
    logic        call_stop2;
    logic [3:0]  digit;
    logic [6:0]  segments;
    logic [15:0] led;

    int          cyc;          // Clock edges since reset release
    int          move_edge;    // Edge of the last bus move
    logic [6:0]  last_loc;
    logic [31:0] rng_state;
    int          exp_rev;
    int          exp_gas;

    bus_top #(
        .STEP_CYCLES (STEP_CYCLES),
        .SCAN_BITS   (SCAN_BITS)
    ) bus_top_i (
        .clk        (clk),
        .global_clk (global_clk),
        .call_stop1 (call_stop1),
        .call_stop2 (call_stop2),
        .digit      (digit),
        .segments   (segments),
        .led        (led)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= global_clk ? 0 : cyc + 1;
    end

    // Bus moves only on step edges, so a move gives the step phase
    always @(negedge clk) begin
        if (!global_clk && led[6:0] !== last_loc) begin
            move_edge = cyc;
        end
        last_loc = led[6:0];
    end

    ////////////////////////////////////////////////////////////
    // Reporting and helpers
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp)
            else abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    function automatic int unsigned lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 8;
    endfunction

    function automatic logic [6:0] seg_pattern(input int value);
        case (value)
            0:       return 7'b1000000;
            1:       return 7'b1111001;
            2:       return 7'b0100100;
            3:       return 7'b0110000;
            4:       return 7'b0011001;
            5:       return 7'b0010010;
            6:       return 7'b0000010;
            7:       return 7'b1111000;
            8:       return 7'b0000000;
            9:       return 7'b0010000;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic int burned_gas(input int level, input int pax);
        return (level > pax * `BUS_GAS_PER_PAX) ? level - pax * `BUS_GAS_PER_PAX : 0;
    endfunction

    task automatic refuel_model();
        while (exp_gas < `BUS_GAS_MAX && exp_rev >= `BUS_REFILL_COST) begin
            exp_rev = exp_rev - `BUS_REFILL_COST;
            exp_gas = exp_gas + `BUS_GAS_REFILL;
            if (exp_gas > `BUS_GAS_MAX) begin
                exp_gas = `BUS_GAS_MAX;
            end
        end
    endtask

    task automatic align_to_step();
        int n;
        if (move_edge < 0) begin
            abort_run("Step phase unknown because the bus has not moved yet");
        end
        for (n = 0; n <= STEP_CYCLES; n++) begin
            @(posedge clk);
            #1;
            if ((cyc - move_edge) % STEP_CYCLES == 0) begin
                return;
            end
        end
        abort_run("Timed out waiting for a step edge");
    endtask

    task automatic wait_trip(input logic [6:0] from_loc, input logic [6:0] to_loc);
        int n;
        for (n = 0; led[6:0] == from_loc; n++) begin
            if (n > TRIP_TIMEOUT) begin
                abort_run("Timed out waiting for the bus to leave its stop");
            end
            @(posedge clk);
            #1;
        end
        for (n = 0; led[6:0] != to_loc || led[10:9] != 2'b00; n++) begin
            if (n > TRIP_TIMEOUT) begin
                abort_run("Timed out waiting for the bus to arrive and unload");
            end
            @(posedge clk);
            #1;
        end
        repeat (6 * STEP_CYCLES) @(posedge clk);   // Terminal refuels finish
        #1;
    endtask

    // Each anode of one full scan against its expected digit
    task automatic check_display();
        logic [3:0] seen;
        int         value;
        int         n;
        seen = 4'b0000;
        for (n = 0; n < (8 << SCAN_BITS) && seen != 4'b1111; n++) begin
            @(negedge clk);
            case (digit)
                4'b1110: value = exp_rev % 10;
                4'b1101: value = exp_rev / 10;
                4'b1011: value = exp_gas % 10;
                4'b0111: value = exp_gas / 10;
                default: abort_run($sformatf("** Error: digit = 0x%0h, expected one anode low",
                                             digit));
            endcase
            check_value("segments", segments, seg_pattern(value));
            seen = seen | ~digit;
        end
        if (seen != 4'b1111) begin
            abort_run("Display scan did not reach all four digits");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed trip test
    ////////////////////////////////////////////////////////////

    task automatic run_trip(input bit stop2, input int calls);
        logic [6:0] from_loc;
        logic [6:0] to_loc;
        int         n;
        int         span;
        int         k;
        from_loc = led[6:0];
        to_loc   = stop2 ? 7'h01 : 7'h40;
        n        = (calls > 2) ? 2 : calls;
        span     = 4;
        if (calls > 1 && from_loc == (stop2 ? 7'h40 : 7'h01)) begin
            align_to_step();    // Group lands between two steps
            span = 2;
        end else begin
            @(posedge clk);
            #1;
        end
        for (k = 0; k < calls; k++) begin
            call_stop1 = !stop2;
            call_stop2 = stop2;
            @(posedge clk);
            #1;
            call_stop1 = 1'b0;
            call_stop2 = 1'b0;
            if (k < calls - 1) begin
                repeat (lcg_next() % span) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        check_value(stop2 ? "led[12:11]" : "led[15:14]",
                    stop2 ? led[12:11] : led[15:14], (n == 2) ? 3 : 2);
        wait_trip(from_loc, to_loc);

        exp_rev = exp_rev + n * (stop2 ? `BUS_FARE_STOP2 : `BUS_FARE_STOP1);
        if (exp_rev > `BUS_REVENUE_MAX) begin
            exp_rev = `BUS_REVENUE_MAX;
        end
        refuel_model();                      // Origin terminal
        exp_gas = burned_gas(exp_gas, n);    // Midpoint
        refuel_model();
        exp_gas = burned_gas(exp_gas, n);    // Arrival
        refuel_model();

        check_value("led", led, to_loc);
        check_display();
    endtask

    initial begin
        int t;
        clk        = 1'b0;
        global_clk = 1'b1;
        call_stop1 = 1'b0;
        call_stop2 = 1'b0;
        move_edge  = -1;
        last_loc   = '0;
        rng_state  = 32'h15eed0a2;
        exp_rev    = 0;
        exp_gas    = 0;
        repeat (4) @(posedge clk);
        #1;
        global_clk = 1'b0;

        check_value("led", led, 16'h0001);
        check_display();
        run_trip(1'b1, 3);      // Empty bus fetches a saturated queue
        run_trip(1'b0, 2);
        run_trip(1'b1, 1);
        for (t = 0; t < 4; t++) begin
            run_trip(t[0], 2);  // Revenue cap trips
        end

        $display("Test passed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
verilog/bus_route_pkg.sv
verilog/bus_display_pkg.sv
verilog/bus_step_timer.sv
verilog/stop_queue.sv
verilog/bus_route_fsm.sv
verilog/bus_display.sv
verilog/bus_top.sv
tests/bus_tb.sv
